//--- hw/mips_pkg.sv
// word and register index types, opcode, funct, alu operation, alu class and forwarding enums
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   localparam int NUM_REGS = 32;

   // primary opcodes, bits 31:26
   typedef enum logic [5:0] {
      OP_R_TYPE = 6'h00,
      OP_ADDI   = 6'h08,
      OP_LW     = 6'h23,
      OP_SW     = 6'h2b
   } opcode_e;

   // r-type function field, bits 5:0
   typedef enum logic [5:0] {
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_SLT = 6'h2a
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   // what main control tells the alu control
   typedef enum logic [1:0] {
      CLS_MEM_ADDR = 2'd0,
      CLS_IMM_ADD  = 2'd1,
      CLS_FUNCT    = 2'd2
   } alu_class_e;

   typedef enum logic [1:0] {
      FWD_REGFILE = 2'd0,
      FWD_EXMEM   = 2'd1,
      FWD_MEMWB   = 2'd2
   } fwd_sel_e;

endpackage

//--- hw/register_file.sv
// 32 x 32-bit register file with write-through reads and register 0 tied to zero
`timescale 1ns/1ps

module register_file (
   input  logic               clk,
   input  logic               rst_n,
   input  mips_pkg::reg_idx_t rs_idx_i,
   input  mips_pkg::reg_idx_t rt_idx_i,
   output mips_pkg::word_t    rs_val_o,
   output mips_pkg::word_t    rt_val_o,
   input  logic               wr_en_i,
   input  mips_pkg::reg_idx_t wr_idx_i,
   input  mips_pkg::word_t    wr_data_i
);

   import mips_pkg::*;

   word_t regs [NUM_REGS];
   logic  wr_live;

   // register 0 never takes a write
   assign wr_live = wr_en_i && (wr_idx_i != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wr_live) begin
         regs[wr_idx_i] <= wr_data_i;
      end
   end

   // same-cycle write shows up on the read side
   assign rs_val_o = (wr_live && (wr_idx_i == rs_idx_i)) ? wr_data_i : regs[rs_idx_i];
   assign rt_val_o = (wr_live && (wr_idx_i == rt_idx_i)) ? wr_data_i : regs[rt_idx_i];

endmodule

//--- hw/fetch_stage.sv
// program counter, instruction word address and if/id register with stall hold
`timescale 1ns/1ps

module fetch_stage (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            stall_i,
   input  mips_pkg::word_t instr_i,
   output mips_pkg::word_t instr_addr_o,
   output mips_pkg::word_t ifid_instr_o,
   output mips_pkg::word_t ifid_pc4_o
);

   import mips_pkg::*;

   word_t pc;
   word_t pc_plus_4;

   assign pc_plus_4    = pc + 32'd4;
   // byte pc to word address
   assign instr_addr_o = pc >> 2;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc           <= '0;
         ifid_instr_o <= '0;
      end
      else if (!stall_i) begin
         pc           <= pc_plus_4;
         ifid_instr_o <= instr_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_i) begin
         ifid_pc4_o <= pc_plus_4;
      end
   end

endmodule

//--- hw/decode_stage.sv
// main control decode, load-use hazard detection, sign extension and id/ex register
`timescale 1ns/1ps

module decode_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mips_pkg::word_t      ifid_instr_i,
   input  logic                 wb_regwrite_i,
   input  mips_pkg::reg_idx_t   wb_dest_i,
   input  mips_pkg::word_t      wb_data_i,
   output logic                 stall_o,
   output mips_pkg::word_t      rs_val_o,
   output mips_pkg::word_t      rt_val_o,
   output mips_pkg::word_t      imm_o,
   output mips_pkg::reg_idx_t   rs_idx_o,
   output mips_pkg::reg_idx_t   rt_idx_o,
   output mips_pkg::reg_idx_t   dest_idx_o,
   output logic [5:0]           funct_o,
   output mips_pkg::alu_class_e alu_class_o,
   output logic                 alusrc_o,
   output logic                 memread_o,
   output logic                 memwrite_o,
   output logic                 memtoreg_o,
   output logic                 regwrite_o
);

   import mips_pkg::*;

   reg_idx_t   rs_idx;
   reg_idx_t   rt_idx;
   reg_idx_t   rd_idx;
   word_t      rs_val;
   word_t      rt_val;
   word_t      imm_ext;
   logic       dec_regdst;
   alu_class_e dec_alu_class;
   logic       dec_alusrc;
   logic       dec_memread;
   logic       dec_memwrite;
   logic       dec_memtoreg;
   logic       dec_regwrite;

   assign rs_idx  = ifid_instr_i[25:21];
   assign rt_idx  = ifid_instr_i[20:16];
   assign rd_idx  = ifid_instr_i[15:11];
   assign imm_ext = {{16{ifid_instr_i[15]}}, ifid_instr_i[15:0]};

   register_file u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs_idx_i (rs_idx),
      .rt_idx_i (rt_idx),
      .rs_val_o (rs_val),
      .rt_val_o (rt_val),
      .wr_en_i  (wb_regwrite_i),
      .wr_idx_i (wb_dest_i),
      .wr_data_i(wb_data_i)
   );

   // unknown opcodes leave all main control bits at zero
   always_comb begin
      dec_regdst    = 1'b0;
      dec_alu_class = CLS_MEM_ADDR;
      dec_alusrc    = 1'b0;
      dec_memread   = 1'b0;
      dec_memwrite  = 1'b0;
      dec_memtoreg  = 1'b0;
      dec_regwrite  = 1'b0;
      case (ifid_instr_i[31:26])
         OP_R_TYPE: begin
            dec_regdst    = 1'b1;
            dec_alu_class = CLS_FUNCT;
            dec_regwrite  = 1'b1;
         end
         OP_ADDI: begin
            dec_alu_class = CLS_IMM_ADD;
            dec_alusrc    = 1'b1;
            dec_regwrite  = 1'b1;
         end
         OP_LW: begin
            dec_alusrc    = 1'b1;
            dec_memread   = 1'b1;
            dec_memtoreg  = 1'b1;
            dec_regwrite  = 1'b1;
         end
         OP_SW: begin
            dec_alusrc    = 1'b1;
            dec_memwrite  = 1'b1;
         end
         default: ;
      endcase
   end

   // load in id/ex feeding an operand of the instruction in if/id
   assign stall_o = memread_o && (dest_idx_o != '0) &&
                    ((dest_idx_o == rs_idx) || (dest_idx_o == rt_idx));

   always_ff @(posedge clk) begin
      if (!rst_n || stall_o) begin
         alu_class_o <= CLS_MEM_ADDR;
         alusrc_o    <= 1'b0;
         memread_o   <= 1'b0;
         memwrite_o  <= 1'b0;
         memtoreg_o  <= 1'b0;
         regwrite_o  <= 1'b0;
      end
      else begin
         alu_class_o <= dec_alu_class;
         alusrc_o    <= dec_alusrc;
         memread_o   <= dec_memread;
         memwrite_o  <= dec_memwrite;
         memtoreg_o  <= dec_memtoreg;
         regwrite_o  <= dec_regwrite;
      end
   end

   always_ff @(posedge clk) begin
      rs_val_o   <= rs_val;
      rt_val_o   <= rt_val;
      imm_o      <= imm_ext;
      rs_idx_o   <= rs_idx;
      rt_idx_o   <= rt_idx;
      dest_idx_o <= dec_regdst ? rd_idx : rt_idx;
      funct_o    <= ifid_instr_i[5:0];
   end

endmodule

//--- hw/execute_stage.sv
// operand forwarding, alu control, alu and ex/mem register
`timescale 1ns/1ps

module execute_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mips_pkg::word_t      rs_val_i,
   input  mips_pkg::word_t      rt_val_i,
   input  mips_pkg::word_t      imm_i,
   input  mips_pkg::reg_idx_t   rs_idx_i,
   input  mips_pkg::reg_idx_t   rt_idx_i,
   input  mips_pkg::reg_idx_t   dest_idx_i,
   input  logic [5:0]           funct_i,
   input  mips_pkg::alu_class_e alu_class_i,
   input  logic                 alusrc_i,
   input  logic                 memread_i,
   input  logic                 memwrite_i,
   input  logic                 memtoreg_i,
   input  logic                 regwrite_i,
   input  logic                 wb_regwrite_i,
   input  mips_pkg::reg_idx_t   wb_dest_i,
   input  mips_pkg::word_t      wb_data_i,
   output mips_pkg::word_t      alu_result_o,
   output mips_pkg::word_t      store_data_o,
   output mips_pkg::reg_idx_t   dest_o,
   output logic                 memread_o,
   output logic                 memwrite_o,
   output logic                 memtoreg_o,
   output logic                 regwrite_o
);

   import mips_pkg::*;

   fwd_sel_e fwd_a;
   fwd_sel_e fwd_b;
   word_t    op_a;
   word_t    rt_fwd;
   word_t    op_b;
   alu_op_e  alu_op;
   word_t    alu_out;

   // ex/mem wins over mem/wb, register 0 never forwards
   function automatic fwd_sel_e pick_src(input reg_idx_t src, input logic exmem_wr,
                                         input reg_idx_t exmem_dest, input logic memwb_wr,
                                         input reg_idx_t memwb_dest);
      fwd_sel_e sel;
      if (exmem_wr && (exmem_dest != '0) && (exmem_dest == src)) begin
         sel = FWD_EXMEM;
      end
      else if (memwb_wr && (memwb_dest != '0) && (memwb_dest == src)) begin
         sel = FWD_MEMWB;
      end
      else begin
         sel = FWD_REGFILE;
      end
      return sel;
   endfunction

   function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                     input word_t exmem_val, input word_t memwb_val);
      word_t val;
      case (sel)
         FWD_EXMEM: val = exmem_val;
         FWD_MEMWB: val = memwb_val;
         default:   val = reg_val;
      endcase
      return val;
   endfunction

   assign fwd_a  = pick_src(rs_idx_i, regwrite_o, dest_o, wb_regwrite_i, wb_dest_i);
   assign fwd_b  = pick_src(rt_idx_i, regwrite_o, dest_o, wb_regwrite_i, wb_dest_i);
   assign op_a   = fwd_mux(fwd_a, rs_val_i, alu_result_o, wb_data_i);
   assign rt_fwd = fwd_mux(fwd_b, rt_val_i, alu_result_o, wb_data_i);
   assign op_b   = alusrc_i ? imm_i : rt_fwd;

   // alu control
   always_comb begin
      alu_op = ALU_ADD;
      if (alu_class_i == CLS_FUNCT) begin
         case (funct_i)
            FN_SUB:  alu_op = ALU_SUB;
            FN_AND:  alu_op = ALU_AND;
            FN_OR:   alu_op = ALU_OR;
            FN_SLT:  alu_op = ALU_SLT;
            default: alu_op = ALU_ADD;
         endcase
      end
   end

   always_comb begin
      case (alu_op)
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_SLT: alu_out = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         default: alu_out = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         memread_o  <= 1'b0;
         memwrite_o <= 1'b0;
         memtoreg_o <= 1'b0;
         regwrite_o <= 1'b0;
      end
      else begin
         memread_o  <= memread_i;
         memwrite_o <= memwrite_i;
         memtoreg_o <= memtoreg_i;
         regwrite_o <= regwrite_i;
      end
   end

   always_ff @(posedge clk) begin
      alu_result_o <= alu_out;
      store_data_o <= rt_fwd;
      dest_o       <= dest_idx_i;
   end

endmodule

//--- hw/mem_writeback_stage.sv
// data ram, mem/wb register, writeback select and led output register
`timescale 1ns/1ps

module mem_writeback_stage #(
   parameter int unsigned        DMEM_WORDS = 64,
   parameter mips_pkg::reg_idx_t LED_REG    = 5'd8
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mips_pkg::word_t    alu_result_i,
   input  mips_pkg::word_t    store_data_i,
   input  mips_pkg::reg_idx_t dest_i,
   input  logic               memread_i,
   input  logic               memwrite_i,
   input  logic               memtoreg_i,
   input  logic               regwrite_i,
   output logic               wb_regwrite_o,
   output mips_pkg::reg_idx_t wb_dest_o,
   output mips_pkg::word_t    wb_data_o,
   output logic [7:0]         led_o
);

   import mips_pkg::*;

   localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

   word_t         dmem [DMEM_WORDS];
   logic [AW-1:0] dmem_idx;
   word_t         rd_word;

   // word addressed from the byte address
   assign dmem_idx = alu_result_i[AW+1:2];
   assign rd_word  = memread_i ? dmem[dmem_idx] : '0;

   always_ff @(posedge clk) begin
      if (memwrite_i) begin
         dmem[dmem_idx] <= store_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_regwrite_o <= 1'b0;
      end
      else begin
         wb_regwrite_o <= regwrite_i;
      end
   end

   always_ff @(posedge clk) begin
      wb_dest_o <= dest_i;
      wb_data_o <= memtoreg_i ? rd_word : alu_result_i;
   end

   // loads alongside the register file write
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         led_o <= '0;
      end
      else if (wb_regwrite_o && (wb_dest_o == LED_REG)) begin
         led_o <= wb_data_o[7:0];
      end
   end

endmodule

//--- hw/mips_pipeline_top.sv
// five-stage pipeline top level connecting fetch, decode, execute and memory/writeback
`timescale 1ns/1ps

module mips_pipeline_top #(
   parameter int unsigned        DMEM_WORDS = 64,
   parameter mips_pkg::reg_idx_t LED_REG    = 5'd8
) (
   input  logic            clk,
   input  logic            rst_n,
   input  mips_pkg::word_t instr_i,
   output mips_pkg::word_t instr_addr_o,
   output logic [7:0]      led_o
);

   import mips_pkg::*;

   // if/id
   word_t      ifid_instr;
   logic       stall;

   // id/ex
   word_t      idex_rs_val;
   word_t      idex_rt_val;
   word_t      idex_imm;
   reg_idx_t   idex_rs_idx;
   reg_idx_t   idex_rt_idx;
   reg_idx_t   idex_dest_idx;
   logic [5:0] idex_funct;
   alu_class_e idex_alu_class;
   logic       idex_alusrc;
   logic       idex_memread;
   logic       idex_memwrite;
   logic       idex_memtoreg;
   logic       idex_regwrite;

   // ex/mem
   word_t      exmem_alu_result;
   word_t      exmem_store_data;
   reg_idx_t   exmem_dest;
   logic       exmem_memread;
   logic       exmem_memwrite;
   logic       exmem_memtoreg;
   logic       exmem_regwrite;

   // mem/wb
   logic       wb_regwrite;
   reg_idx_t   wb_dest;
   word_t      wb_data;

   fetch_stage u_fetch (
      .clk          (clk),
      .rst_n        (rst_n),
      .stall_i      (stall),
      .instr_i      (instr_i),
      .instr_addr_o (instr_addr_o),
      .ifid_instr_o (ifid_instr),
      .ifid_pc4_o   ()
   );

   decode_stage u_decode (
      .clk           (clk),
      .rst_n         (rst_n),
      .ifid_instr_i  (ifid_instr),
      .wb_regwrite_i (wb_regwrite),
      .wb_dest_i     (wb_dest),
      .wb_data_i     (wb_data),
      .stall_o       (stall),
      .rs_val_o      (idex_rs_val),
      .rt_val_o      (idex_rt_val),
      .imm_o         (idex_imm),
      .rs_idx_o      (idex_rs_idx),
      .rt_idx_o      (idex_rt_idx),
      .dest_idx_o    (idex_dest_idx),
      .funct_o       (idex_funct),
      .alu_class_o   (idex_alu_class),
      .alusrc_o      (idex_alusrc),
      .memread_o     (idex_memread),
      .memwrite_o    (idex_memwrite),
      .memtoreg_o    (idex_memtoreg),
      .regwrite_o    (idex_regwrite)
   );

   execute_stage u_execute (
      .clk           (clk),
      .rst_n         (rst_n),
      .rs_val_i      (idex_rs_val),
      .rt_val_i      (idex_rt_val),
      .imm_i         (idex_imm),
      .rs_idx_i      (idex_rs_idx),
      .rt_idx_i      (idex_rt_idx),
      .dest_idx_i    (idex_dest_idx),
      .funct_i       (idex_funct),
      .alu_class_i   (idex_alu_class),
      .alusrc_i      (idex_alusrc),
      .memread_i     (idex_memread),
      .memwrite_i    (idex_memwrite),
      .memtoreg_i    (idex_memtoreg),
      .regwrite_i    (idex_regwrite),
      .wb_regwrite_i (wb_regwrite),
      .wb_dest_i     (wb_dest),
      .wb_data_i     (wb_data),
      .alu_result_o  (exmem_alu_result),
      .store_data_o  (exmem_store_data),
      .dest_o        (exmem_dest),
      .memread_o     (exmem_memread),
      .memwrite_o    (exmem_memwrite),
      .memtoreg_o    (exmem_memtoreg),
      .regwrite_o    (exmem_regwrite)
   );

   mem_writeback_stage #(
      .DMEM_WORDS (DMEM_WORDS),
      .LED_REG    (LED_REG)
   ) u_mem_wb (
      .clk           (clk),
      .rst_n         (rst_n),
      .alu_result_i  (exmem_alu_result),
      .store_data_i  (exmem_store_data),
      .dest_i        (exmem_dest),
      .memread_i     (exmem_memread),
      .memwrite_i    (exmem_memwrite),
      .memtoreg_i    (exmem_memtoreg),
      .regwrite_i    (exmem_regwrite),
      .wb_regwrite_o (wb_regwrite),
      .wb_dest_o     (wb_dest),
      .wb_data_o     (wb_data),
      .led_o         (led_o)
   );

endmodule

//--- test/tb_clock_gen.sv
// free-running testbench clock, 100 ns period
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD_NS = 50
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(HALF_PERIOD_NS) clk_o = ~clk_o;
      end
   end

endmodule

//--- test/tb_checker.sv
// checker that follows instr_addr_o and led_o, compares them with expected values and counts errors
`timescale 1ns/1ps

module tb_checker (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] instr_addr_i,
   input  logic [7:0]  led_i,
   input  int unsigned exp_count_i,
   input  logic [7:0]  exp_led_i [32],
   input  int unsigned hold_count_i,
   input  logic [31:0] hold_addr_i [8],
   input  logic        finish_i,
   output int unsigned error_count_o,
   output logic        report_done_o
);

   int unsigned addr_errors  = 0;
   int unsigned led_errors   = 0;
   int unsigned other_errors = 0;
   int unsigned seen         = 0;
   logic [31:0] exp_addr     = '0;
   logic        held         = 1'b0;
   logic [7:0]  last_led     = 8'h00;
   logic        reset_seen   = 1'b0;
   logic        running      = 1'b0;
   logic        finish_q     = 1'b0;
   logic        done_q       = 1'b0;

   assign error_count_o = addr_errors + led_errors + other_errors;
   assign report_done_o = done_q;

   // address that stays up one extra cycle behind a load-use pair
   function automatic logic is_hold(input logic [31:0] addr);
      logic hit;
      hit = 1'b0;
      for (int k = 0; k < 8; k++) begin
         if ((k < hold_count_i) && (hold_addr_i[3'(k)] == addr)) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   task automatic check_address();
      if (!running) begin
         exp_addr = '0;
         held     = 1'b0;
      end
      else if (is_hold(exp_addr) && !held) begin
         held = 1'b1;
      end
      else begin
         exp_addr = exp_addr + 32'd1;
         held     = 1'b0;
      end
      if (instr_addr_i !== exp_addr) begin
         addr_errors++;
         $display("MISMATCH at %0t: instr_addr_o = %0d, expected %0d",
                  $time, instr_addr_i, exp_addr);
      end
   endtask

   task automatic check_led();
      if (!running) begin
         last_led = 8'h00;
         if (led_i !== 8'h00) begin
            led_errors++;
            $display("MISMATCH at %0t: led_o = %02h in reset, expected 00", $time, led_i);
         end
      end
      else if (led_i !== last_led) begin
         if (seen >= exp_count_i) begin
            other_errors++;
            $display("led_o changed to %02h at %0t after all expected values", led_i, $time);
         end
         else if (led_i !== exp_led_i[5'(seen)]) begin
            led_errors++;
            $display("MISMATCH at %0t: led_o = %02h, expected %02h (value %0d)",
                     $time, led_i, exp_led_i[5'(seen)], seen);
         end
         seen++;
         last_led = led_i;
      end
   endtask

   task automatic print_summary();
      if (seen < exp_count_i) begin
         other_errors++;
         $display("only %0d of %0d expected led_o values were seen", seen, exp_count_i);
      end
      $display("checker: %0d address errors, %0d led errors, %0d other errors",
               addr_errors, led_errors, other_errors);
      done_q <= 1'b1;
   endtask

   // reset and finish are sampled where they are stable
   always @(posedge clk) begin
      running  <= rst_n;
      finish_q <= finish_i;
      if (!rst_n) begin
         reset_seen <= 1'b1;
      end
   end

   always @(negedge clk) begin
      if (reset_seen && !done_q) begin
         check_address();
         check_led();
         if (finish_q) begin
            print_summary();
         end
      end
   end

endmodule

//--- test/tb_mips.sv
// testbench top with vector loading, instruction memory model, reset, dut, checker and watchdog
`timescale 1ns/1ps

module tb_mips;

   logic        clk;
   logic        rst_n;
   logic [31:0] instr;
   logic [31:0] instr_addr;
   logic [7:0]  led;
   logic        finish;
   logic        report_done;
   logic        loaded = 1'b0;
   int unsigned error_count;

   logic [31:0] vec_mem   [128];
   logic [31:0] prog_mem  [64];
   logic [7:0]  exp_led   [32];
   logic [31:0] hold_addr [8];
   int unsigned prog_len   = 0;
   int unsigned exp_count  = 0;
   int unsigned hold_count = 0;

   tb_clock_gen u_clk (
      .clk_o (clk)
   );

   mips_pipeline_top #(
      .DMEM_WORDS (64),
      .LED_REG    (5'd8)
   ) dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr_i      (instr),
      .instr_addr_o (instr_addr),
      .led_o        (led)
   );

   tb_checker u_checker (
      .clk           (clk),
      .rst_n         (rst_n),
      .instr_addr_i  (instr_addr),
      .led_i         (led),
      .exp_count_i   (exp_count),
      .exp_led_i     (exp_led),
      .hold_count_i  (hold_count),
      .hold_addr_i   (hold_addr),
      .finish_i      (finish),
      .error_count_o (error_count),
      .report_done_o (report_done)
   );

   // combinational instruction memory that returns zero past the program
   always_comb begin
      if (instr_addr < prog_len) begin
         instr = prog_mem[instr_addr[5:0]];
      end
      else begin
         instr = 32'h0;
      end
   end

   // lw whose destination is a nonzero source field of the next word
   function automatic logic is_load_use(input logic [31:0] load_word,
                                        input logic [31:0] next_word);
      logic [4:0] dest;
      dest = load_word[20:16];
      return (load_word[31:26] == 6'h23) && (dest != 5'd0) &&
             ((next_word[25:21] == dest) || (next_word[20:16] == dest));
   endfunction

   task automatic load_vectors();
      int unsigned base;
      $readmemh("test/mips_vectors.hex", vec_mem);
      prog_len = (vec_mem[0] > 64) ? 64 : vec_mem[0];
      for (int unsigned i = 0; i < prog_len; i++) begin
         prog_mem[6'(i)] = vec_mem[7'(i + 1)];
      end
      base      = prog_len + 1;
      exp_count = (vec_mem[7'(base)] > 32) ? 32 : vec_mem[7'(base)];
      for (int unsigned j = 0; j < exp_count; j++) begin
         exp_led[5'(j)] = vec_mem[7'(base + 1 + j)][7:0];
      end
      // fetch sits on the word after the dependent one during the stall
      hold_count = 0;
      for (int unsigned i = 0; i + 1 < prog_len; i++) begin
         if (is_load_use(prog_mem[6'(i)], prog_mem[6'(i + 1)]) && (hold_count < 8)) begin
            hold_addr[3'(hold_count)] = i + 2;
            hold_count++;
         end
      end
   endtask

   initial begin
      rst_n  = 1'b0;
      finish = 1'b0;
      load_vectors();
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // run past the program end until the last writebacks have landed
      while (instr_addr < prog_len + 8) begin
         @(negedge clk);
      end
      finish = 1'b1;
      while (!report_done) begin
         @(negedge clk);
      end
      if (error_count == 0) begin
         $display("*** PASSED ***");
      end
      else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin : watchdog
      int unsigned limit;
      wait (loaded);
      limit = (prog_len + exp_count + 40) * 10;
      repeat (limit) @(posedge clk);
      $display("timeout: the run did not finish within %0d clock cycles", limit);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- test/mips_vectors.hex
// word 0 is the program length N, then N instruction words,
// then the LED count M and M expected led_o bytes in order
18        // N = 24
20010005  // 0  addi r1, r0, 5
2002000C  // 1  addi r2, r0, 12
00224020  // 2  add  r8, r1, r2
00414022  // 3  sub  r8, r2, r1
00224024  // 4  and  r8, r1, r2
00224025  // 5  or   r8, r1, r2
0022402A  // 6  slt  r8, r1, r2
2003FFFD  // 7  addi r3, r0, -3
0023402A  // 8  slt  r8, r1, r3
20040040  // 9  addi r4, r0, 0x40
2005005A  // 10 addi r5, r0, 0x5a
AC850000  // 11 sw   r5, 0(r4)
8C860000  // 12 lw   r6, 0(r4)
00C04020  // 13 add  r8, r6, r0
20070033  // 14 addi r7, r0, 0x33
AC870004  // 15 sw   r7, 4(r4)
8C880004  // 16 lw   r8, 4(r4)
21090010  // 17 addi r9, r8, 0x10
01204020  // 18 add  r8, r9, r0
00220020  // 19 add  r0, r1, r2
FC281234  // 20 unknown opcode 0x3f
00014020  // 21 add  r8, r0, r1
21080020  // 22 addi r8, r8, 0x20
01034025  // 23 or   r8, r8, r3
0C        // M = 12
11        // 5 + 12
07        // 12 - 5
04        // 5 and 12
0D        // 5 or 12
01        // 5 < 12
00        // 5 < -3
5A        // stored word through a load-use pair
33        // lw straight into r8
43        // addi on the loaded value
05        // r0 stays zero
25        // distance 1 on r8
FD        // or with -3

//--- mips_pipeline.f
hw/mips_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_writeback_stage.sv
hw/mips_pipeline_top.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_mips.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_mips
FILELIST = mips_pipeline.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
